/* bus_stim.txt */
# op addr data strb exp, all hex
# W exp = ack latency (0 = load write), R exp = read word, M exp = main RAM byte
# O addr: 0 osd_ctrl 1 kbd_mask lo 2 kbd_mask hi 3 core_rst; P addr = cycles watched
P 00000020 00000000 0 00000000
O 00000003 00000000 0 00000001
W 10000010 11223344 f 00000001
W 10000014 000000aa 1 00000001
W 10000014 0000bb00 2 00000001
W 10000014 00cc0000 4 00000001
W 10000014 dd000000 8 00000001
R 10000014 00000000 0 ddccbbaa
R 10000010 00000000 0 11223344
W 10000014 99999999 6 00000001
R 10000014 00000000 0 dd9999aa
W 30000000 00000003 f 00000001
O 00000000 00000000 0 00000003
W 30000004 89abcdef f 00000001
W 30000008 01234567 f 00000001
O 00000001 00000000 0 89abcdef
O 00000002 00000000 0 01234567
W 30000000 00000000 7 00000001
O 00000000 00000000 0 00000003
W 3000000c ffffffd5 f 00000001
R 3000000c 00000000 0 00000055
R 30000000 00000000 0 00000000
R 30000004 00000000 0 00000000
P 00000008 00000000 0 00000000
O 00000003 00000000 0 00000000
W 3000000c 0000002a f 00000001
P 00000008 00000000 0 00000000
O 00000003 00000000 0 00000001
W 50001234 000000a1 1 00000000
W 50001234 0000b200 2 00000000
W 50001234 00c30000 4 00000000
W 50002001 d4000000 8 00000000
M 00001234 00000000 0 000000a1
M 00001235 00000000 0 000000b2
M 00001236 00000000 0 000000c3
M 00002003 00000000 0 000000d4
R 80000000 00000000 0 00000000
P 00000020 00000000 0 00000000

/* sources.f */
+incdir+.
c64_bus_pkg.sv
phase_gen.sv
bus_ctrl.sv
scratch_ram.sv
ctrl_regs.sv
load_port.sv
sys_bus_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

/* Makefile */
# Verilator build and run of the system bus testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

/* tb_top.sv */
////////////////////////////////////////////////////////////////////////////
// testbench top that plays the soft cpu bus master from bus_stim.txt
// it also drives the machine-side read port and bounds the run with a timeout
////////////////////////////////////////////////////////////////////////////

module tb_top;

  import c64_bus_pkg::*;

  logic       clk_8mhz;
  logic       rst;
  logic       mem_valid;
  bus_addr_t  mem_addr;
  bus_data_t  mem_wdata;
  byte_strb_t mem_wstrb;
  bus_data_t  mem_rdata;
  logic       mem_ready;
  main_addr_t main_addr;
  byte_t      main_rdata;
  logic       ph1_en;
  logic       ph2_en;
  logic       core_rst;
  osd_ctrl_t  osd_ctrl;
  kbd_mask_t  kbd_mask;

  // one entry per stim line
  byte         op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] strb_q[$];
  logic [31:0] exp_q[$];

  int cycle_count = 0;
  int cycle_limit = 100;
  int gap;

  tb_clock_gen clock_gen_i (.clk_8mhz(clk_8mhz), .rst(rst));

  sys_bus_top dut_i (
    .clk_8mhz   (clk_8mhz),
    .rst        (rst),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_rdata  (mem_rdata),
    .mem_ready  (mem_ready),
    .main_addr  (main_addr),
    .main_rdata (main_rdata),
    .ph1_en     (ph1_en),
    .ph2_en     (ph2_en),
    .core_rst   (core_rst),
    .osd_ctrl   (osd_ctrl),
    .kbd_mask   (kbd_mask)
  );

  tb_checker checker_i (
    .clk_8mhz   (clk_8mhz),
    .rst        (rst),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wstrb  (mem_wstrb),
    .mem_rdata  (mem_rdata),
    .mem_ready  (mem_ready),
    .main_rdata (main_rdata),
    .ph1_en     (ph1_en),
    .ph2_en     (ph2_en),
    .core_rst   (core_rst),
    .osd_ctrl   (osd_ctrl),
    .kbd_mask   (kbd_mask)
  );

  always @(posedge clk_8mhz) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic read_stim();
    int fd;
    int n;
    string line;
    byte op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    fd = $fopen("bus_stim.txt", "r");
    if (fd == 0) begin
      checker_i.note_failure("could not open bus_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          if ($sscanf(line, "%c %h %h %h %h", op, a, d, s, e) == 5) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            strb_q.push_back(s);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_8mhz);
      #1;
    end
  endtask

  // request held until ready and dropped in the following cycle
  task automatic bus_access(input bus_addr_t a, input bus_data_t d, input byte_strb_t s);
    mem_valid = 1'b1;
    mem_addr  = a;
    mem_wdata = d;
    mem_wstrb = s;
    @(posedge clk_8mhz);
    while (!mem_ready) begin
      @(posedge clk_8mhz);
    end
    #1;
    mem_valid = 1'b0;
    mem_wstrb = '0;
  endtask

  task automatic run_op(input int i);
    case (op_q[i])
      "W": begin
        bus_access(addr_q[i], data_q[i], strb_q[i][3:0]);
        checker_i.check_write(exp_q[i]);
      end
      "R": begin
        bus_access(addr_q[i], '0, '0);
        checker_i.check_read(exp_q[i]);
      end
      "M": begin
        main_addr = addr_q[i][15:0];
        wait_cycles(1);
        checker_i.check_main(exp_q[i][7:0]);
      end
      "O": begin
        checker_i.check_output(addr_q[i], exp_q[i]);
      end
      "P": begin
        checker_i.start_window();
        wait_cycles(addr_q[i]);
        checker_i.check_window(addr_q[i]);
      end
      default: begin
        checker_i.note_failure("unknown operation in the stim file");
      end
    endcase
  endtask

  initial begin
    mem_valid = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    main_addr = '0;
    void'($urandom(32'h602b7ed9));
    read_stim();
    cycle_limit = op_q.size() * 20 + 100;
    @(negedge rst);
    for (int i = 0; i < op_q.size(); i++) begin
      checker_i.begin_test();
      run_op(i);
      checker_i.end_test(i, $sformatf("%c %08h", op_q[i], addr_q[i]));
      // idle gap moves the next access to another phase
      gap = $urandom % 4;
      wait_cycles(gap);
    end
    checker_i.report_counts();
    if (checker_i.total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tb_checker.sv */
////////////////////////////////////////////////////////////////////////////
// testbench checker: watches the DUT ports every cycle for phase, reset
// and ack rules, and compares the values the bus master expects
////////////////////////////////////////////////////////////////////////////

module tb_checker (
  input logic                     clk_8mhz,
  input logic                     rst,
  input logic                     mem_valid,
  input c64_bus_pkg::bus_addr_t   mem_addr,
  input c64_bus_pkg::byte_strb_t  mem_wstrb,
  input c64_bus_pkg::bus_data_t   mem_rdata,
  input logic                     mem_ready,
  input c64_bus_pkg::byte_t       main_rdata,
  input logic                     ph1_en,
  input logic                     ph2_en,
  input logic                     core_rst,
  input c64_bus_pkg::osd_ctrl_t   osd_ctrl,
  input c64_bus_pkg::kbd_mask_t   kbd_mask
);

  import c64_bus_pkg::*;

  int check_errors = 0;
  int monitor_errors = 0;
  int errors_at_start = 0;
  int test_count = 0;
  int fail_count = 0;

  // written by the cycle monitor only
  int        wait_cnt = 0;
  int        last_latency = 0;
  bus_data_t last_rdata = '0;
  int        cyc_after_rst = 0;
  int        since_ph1 = 0;
  logic      seen_ph1 = 1'b0;
  logic      prev_core_rst = 1'b1;
  logic      prev_ph2 = 1'b0;
  int        ph1_total = 0;
  int        ph2_total = 0;

  int ph1_mark = 0;
  int ph2_mark = 0;

  function automatic int total_errors();
    return check_errors + monitor_errors;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // cycle monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_8mhz) begin
    if (rst) begin
      wait_cnt = 0;
      cyc_after_rst = 0;
      seen_ph1 = 1'b0;
      prev_core_rst = core_rst;
      prev_ph2 = 1'b0;
    end else begin
      if (ph1_en && ph2_en) begin
        monitor_errors++;
        $display("ph1_en and ph2_en were high in the same cycle");
      end
      if (ph1_en && !seen_ph1 && cyc_after_rst != 0) begin
        monitor_errors++;
        $display("first ph1_en came %0d cycles after reset", cyc_after_rst);
      end
      if (ph1_en && seen_ph1 && since_ph1 != 8) begin
        monitor_errors++;
        $display("ph1_en repeated after %0d cycles instead of 8", since_ph1);
      end
      if (ph2_en && (!seen_ph1 || since_ph1 != 4)) begin
        monitor_errors++;
        $display("ph2_en came %0d cycles after ph1_en instead of 4", since_ph1);
      end
      if (core_rst != prev_core_rst && !prev_ph2) begin
        monitor_errors++;
        $display("core_rst changed without a ph2_en pulse before it");
      end
      if (mem_ready && !mem_valid) begin
        monitor_errors++;
        $display("mem_ready was high while mem_valid was low");
      end
      if (mem_ready && mem_addr[31:16] == 16'h5000 && mem_wstrb != '0 && !ph1_en) begin
        monitor_errors++;
        $display("load write was acknowledged outside a ph1_en cycle");
      end
      if (mem_valid && !mem_ready) begin
        wait_cnt++;
      end
      if (mem_ready) begin
        last_latency = wait_cnt;
        last_rdata = mem_rdata;
        wait_cnt = 0;
      end
      if (ph1_en) begin
        ph1_total++;
      end
      if (ph2_en) begin
        ph2_total++;
      end
      since_ph1 = ph1_en ? 1 : since_ph1 + 1;
      if (ph1_en) begin
        seen_ph1 = 1'b1;
      end
      prev_core_rst = core_rst;
      prev_ph2 = ph2_en;
      cyc_after_rst++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // comparisons called by the bus master
  ////////////////////////////////////////////////////////////////////////////

  task automatic note_failure(input string msg);
    check_errors++;
    $display("%s", msg);
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      check_errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // zero marks a load write, whose ack waits for the phases
  task automatic check_write(input logic [31:0] exp_latency);
    if (exp_latency == 0) begin
      if (last_latency < 5 || last_latency > 12) begin
        note_failure($sformatf("load write took %0d cycles, outside 5 to 12", last_latency));
      end
    end else begin
      compare("ack latency", 64'(last_latency), {32'h0, exp_latency});
    end
  endtask

  task automatic check_read(input logic [31:0] exp);
    compare("ack latency", 64'(last_latency), 64'h1);
    compare("mem_rdata", {32'h0, last_rdata}, {32'h0, exp});
  endtask

  task automatic check_main(input logic [7:0] exp);
    compare("main_rdata", {56'h0, main_rdata}, {56'h0, exp});
  endtask

  task automatic check_output(input logic [31:0] sel, input logic [31:0] exp);
    case (sel)
      0: compare("osd_ctrl", {62'h0, osd_ctrl}, {32'h0, exp});
      1: compare("kbd_mask[31:0]", {32'h0, kbd_mask[31:0]}, {32'h0, exp});
      2: compare("kbd_mask[63:32]", {32'h0, kbd_mask[63:32]}, {32'h0, exp});
      3: compare("core_rst", {63'h0, core_rst}, {32'h0, exp});
      default: note_failure("output check names an unknown signal");
    endcase
  endtask

  task automatic start_window();
    ph1_mark = ph1_total;
    ph2_mark = ph2_total;
  endtask

  task automatic check_window(input logic [31:0] cycles);
    compare("ph1_en pulses", 64'(ph1_total - ph1_mark), {32'h0, cycles / 8});
    compare("ph2_en pulses", 64'(ph2_total - ph2_mark), {32'h0, cycles / 8});
  endtask

  task automatic begin_test();
    errors_at_start = total_errors();
  endtask

  task automatic end_test(input int idx, input string what);
    test_count++;
    if (total_errors() == errors_at_start) begin
      $display("test %0d (%s) passed", idx, what);
    end else begin
      fail_count++;
      $display("test %0d (%s) failed", idx, what);
    end
  endtask

  task automatic report_counts();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             test_count, test_count - fail_count, fail_count, total_errors());
  endtask

endmodule

/* tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset: clk_8mhz with a period of 8 units,
// rst held high for the first two rising edges
////////////////////////////////////////////////////////////////////////////

module tb_clock_gen (
  output logic clk_8mhz,
  output logic rst
);

  initial begin
    clk_8mhz = 1'b0;
    forever #4 clk_8mhz = ~clk_8mhz;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk_8mhz);
    #1 rst = 1'b0;
  end

endmodule

/* sys_bus_top.sv */
////////////////////////////////////////////////////////////////////////////
// system bus of the emulation core as seen by the soft cpu
// ties the bus control to scratch RAM, registers, load port and phases
////////////////////////////////////////////////////////////////////////////

`include "c64_bus_config.svh"

module sys_bus_top (
  input  logic                       clk_8mhz,
  input  logic                       rst,
  input  logic                       mem_valid,
  input  c64_bus_pkg::bus_addr_t      mem_addr,
  input  c64_bus_pkg::bus_data_t      mem_wdata,
  input  c64_bus_pkg::byte_strb_t     mem_wstrb,
  output c64_bus_pkg::bus_data_t      mem_rdata,
  output logic                       mem_ready,
  input  c64_bus_pkg::main_addr_t     main_addr,
  output c64_bus_pkg::byte_t          main_rdata,
  output logic                       ph1_en,
  output logic                       ph2_en,
  output logic                       core_rst,
  output c64_bus_pkg::osd_ctrl_t      osd_ctrl,
  output c64_bus_pkg::kbd_mask_t      kbd_mask
);

  import c64_bus_pkg::*;

  logic          scratch_sel;
  logic          reg_sel;
  logic          load_sel;
  logic          load_done;
  bus_data_t     scratch_rdata;
  bus_data_t     reg_rdata;
  machine_ctrl_t machine_ctrl;

  phase_gen phase_gen_i (
    .clk_8mhz (clk_8mhz),
    .rst      (rst),
    .core_run (machine_ctrl[0]),
    .ph1_en   (ph1_en),
    .ph2_en   (ph2_en),
    .core_rst (core_rst)
  );

  bus_ctrl bus_ctrl_i (
    .clk_8mhz      (clk_8mhz),
    .rst           (rst),
    .mem_valid     (mem_valid),
    .mem_addr      (mem_addr),
    .mem_wstrb     (mem_wstrb),
    .load_done     (load_done),
    .scratch_rdata (scratch_rdata),
    .reg_rdata     (reg_rdata),
    .scratch_sel   (scratch_sel),
    .reg_sel       (reg_sel),
    .load_sel      (load_sel),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata)
  );

  scratch_ram scratch_ram_i (
    .clk_8mhz      (clk_8mhz),
    .scratch_sel   (scratch_sel),
    .word_addr     (mem_addr[`SCRATCH_AW+1:2]),
    .mem_wdata     (mem_wdata),
    .mem_wstrb     (mem_wstrb),
    .scratch_rdata (scratch_rdata)
  );

  ctrl_regs ctrl_regs_i (
    .clk_8mhz     (clk_8mhz),
    .rst          (rst),
    .reg_sel      (reg_sel),
    .reg_offset   (mem_addr[7:0]),
    .mem_wdata    (mem_wdata),
    .mem_wstrb    (mem_wstrb),
    .osd_ctrl     (osd_ctrl),
    .kbd_mask     (kbd_mask),
    .machine_ctrl (machine_ctrl),
    .reg_rdata    (reg_rdata)
  );

  load_port load_port_i (
    .clk_8mhz   (clk_8mhz),
    .load_sel   (load_sel),
    .ph1_en     (ph1_en),
    .ph2_en     (ph2_en),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .main_addr  (main_addr),
    .main_rdata (main_rdata),
    .load_done  (load_done)
  );

endmodule

/* load_port.sv */
////////////////////////////////////////////////////////////////////////////
// load port into the emulated main RAM. one strobed byte per bus write,
// held from ph2 to the next ph1 like a real machine cycle
////////////////////////////////////////////////////////////////////////////

`include "c64_bus_config.svh"

module load_port (
  input  logic                    clk_8mhz,
  input  logic                    load_sel,
  input  logic                    ph1_en,
  input  logic                    ph2_en,
  input  c64_bus_pkg::bus_addr_t   mem_addr,
  input  c64_bus_pkg::bus_data_t   mem_wdata,
  input  c64_bus_pkg::byte_strb_t  mem_wstrb,
  input  c64_bus_pkg::main_addr_t  main_addr,
  output c64_bus_pkg::byte_t       main_rdata,
  output logic                    load_done
);

  import c64_bus_pkg::*;

  logic [1:0] lane;
  main_addr_t load_addr;
  byte_t      load_byte;
  main_addr_t ram_addr;
  logic       wr_active;

  byte_t main_ram [0:(2**`MAIN_RAM_AW)-1];

  // one-hot strobe to byte lane
  always_comb begin
    case (mem_wstrb)
      4'b0010: lane = 2'd1;
      4'b0100: lane = 2'd2;
      4'b1000: lane = 2'd3;
      default: lane = 2'd0;
    endcase
    load_addr = {mem_addr[`MAIN_RAM_AW-1:2], lane};
    load_byte = mem_wdata[8*lane +: 8];
  end

  // pending bus write from ph2 to the next ph1
  always_ff @(posedge clk_8mhz) begin
    if (ph2_en) begin
      wr_active <= load_sel;
    end else if (ph1_en) begin
      wr_active <= 1'b0;
    end
  end

  assign load_done = wr_active && ph1_en;

  // bus write owns the address for the whole ph2 half
  assign ram_addr = wr_active ? load_addr : main_addr;

  always_ff @(posedge clk_8mhz) begin
    if (wr_active) begin
      main_ram[ram_addr] <= load_byte;
    end
    main_rdata <= main_ram[ram_addr];
  end

  a_load_onehot : assert property (@(posedge clk_8mhz) load_sel |-> $onehot(mem_wstrb));

endmodule

/* ctrl_regs.sv */
////////////////////////////////////////////////////////////////////////////
// machine control registers in region 3: overlay control, keyboard mask
// and machine control. writes need all four strobes
////////////////////////////////////////////////////////////////////////////

`include "c64_bus_config.svh"

module ctrl_regs (
  input  logic                         clk_8mhz,
  input  logic                         rst,
  input  logic                         reg_sel,
  input  c64_bus_pkg::byte_t           reg_offset,
  input  c64_bus_pkg::bus_data_t       mem_wdata,
  input  c64_bus_pkg::byte_strb_t      mem_wstrb,
  output c64_bus_pkg::osd_ctrl_t       osd_ctrl,
  output c64_bus_pkg::kbd_mask_t       kbd_mask,
  output c64_bus_pkg::machine_ctrl_t   machine_ctrl,
  output c64_bus_pkg::bus_data_t       reg_rdata
);

  import c64_bus_pkg::*;

  logic word_wr;

  // partial strobes are dropped
  assign word_wr = reg_sel && (mem_wstrb == '1);

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      osd_ctrl     <= '0;
      kbd_mask     <= '0;
      machine_ctrl <= '0;
    end else if (word_wr) begin
      case (reg_offset)
        `REG_OSD: begin
          osd_ctrl <= mem_wdata[$bits(osd_ctrl_t)-1:0];
        end
        `REG_KBD_LO: begin
          kbd_mask[31:0] <= mem_wdata;
        end
        `REG_KBD_HI: begin
          kbd_mask[63:32] <= mem_wdata;
        end
        `REG_MACHINE: begin
          machine_ctrl <= mem_wdata[`MACHINE_CTRL_W-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // only the machine register reads back
  always_comb begin
    if (reg_offset == `REG_MACHINE) begin
      reg_rdata = {{(32-`MACHINE_CTRL_W){1'b0}}, machine_ctrl};
    end else begin
      reg_rdata = '0;
    end
  end

endmodule

/* scratch_ram.sv */
////////////////////////////////////////////////////////////////////////////
// word-wide scratch RAM for the soft cpu, built from four byte lanes
// each lane writes on its own strobe, reads come back one cycle later
////////////////////////////////////////////////////////////////////////////

`include "c64_bus_config.svh"

module scratch_ram (
  input  logic                     clk_8mhz,
  input  logic                     scratch_sel,
  input  logic [`SCRATCH_AW-1:0]   word_addr,
  input  c64_bus_pkg::bus_data_t   mem_wdata,
  input  c64_bus_pkg::byte_strb_t  mem_wstrb,
  output c64_bus_pkg::bus_data_t   scratch_rdata
);

  import c64_bus_pkg::*;

  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    byte_t lane_mem [0:(2**`SCRATCH_AW)-1];
    byte_t lane_q;

    always_ff @(posedge clk_8mhz) begin
      if (scratch_sel) begin
        if (mem_wstrb[lane]) begin
          lane_mem[word_addr] <= mem_wdata[8*lane +: 8];
        end
        // old contents on a write, the bus ignores it
        lane_q <= lane_mem[word_addr];
      end
    end

    assign scratch_rdata[8*lane +: 8] = lane_q;
  end

endmodule

/* bus_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// system bus control: region decode, ready generation and read data mux
// immediate regions ack one cycle after valid, load writes wait for ph1
////////////////////////////////////////////////////////////////////////////

`include "c64_bus_config.svh"

module bus_ctrl (
  input  logic                   clk_8mhz,
  input  logic                   rst,
  input  logic                   mem_valid,
  input  c64_bus_pkg::bus_addr_t  mem_addr,
  input  c64_bus_pkg::byte_strb_t mem_wstrb,
  input  logic                   load_done,
  input  c64_bus_pkg::bus_data_t  scratch_rdata,
  input  c64_bus_pkg::bus_data_t  reg_rdata,
  output logic                   scratch_sel,
  output logic                   reg_sel,
  output logic                   load_sel,
  output logic                   mem_ready,
  output c64_bus_pkg::bus_data_t  mem_rdata
);

  import c64_bus_pkg::*;

  bus_state_e state;
  bus_state_e state_nxt;

  logic hit_scratch;
  logic hit_regs;
  logic hit_load;
  logic new_req;

  ////////////////////////////////////////////////////////////////////////////
  // region decode
  ////////////////////////////////////////////////////////////////////////////

  assign hit_scratch = (mem_addr[31:28] == `REGION_SCRATCH);
  assign hit_regs    = (mem_addr[31:28] == `REGION_REGS);

  // reads of the load window fall through to the unmapped path
  assign hit_load = (mem_addr[31:16] == `LOAD_BASE) && (mem_wstrb != '0);

  // a request is taken once, in IDLE
  assign new_req = (state == IDLE) && mem_valid;

  assign scratch_sel = new_req && hit_scratch;
  assign reg_sel     = new_req && hit_regs;
  assign load_sel    = (state == WAIT_LOAD);

  ////////////////////////////////////////////////////////////////////////////
  // ready state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (mem_valid) begin
          state_nxt = hit_load ? WAIT_LOAD : ACK;
        end
      end
      WAIT_LOAD: begin
        // ack rides the ph1 cycle that ends the byte write
        if (load_done) begin
          state_nxt = IDLE;
        end
      end
      ACK: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign mem_ready = (state == ACK) || (load_sel && load_done);

  // unmapped and load accesses read zero
  always_comb begin
    if (hit_scratch) begin
      mem_rdata = scratch_rdata;
    end else if (hit_regs) begin
      mem_rdata = reg_rdata;
    end else begin
      mem_rdata = '0;
    end
  end

  a_ready_valid : assert property (@(posedge clk_8mhz) disable iff (rst) mem_ready |-> mem_valid);

endmodule

/* phase_gen.sv */
////////////////////////////////////////////////////////////////////////////
// 1 MHz ph1/ph2 enables from the 8 MHz clock and the phase-aligned core
// reset, so the machine always starts on a ph1 after release
////////////////////////////////////////////////////////////////////////////

`include "c64_bus_config.svh"

module phase_gen (
  input  logic clk_8mhz,
  input  logic rst,
  input  logic core_run,
  output logic ph1_en,
  output logic ph2_en,
  output logic core_rst
);

  logic [`PHASE_W-1:0] phase_cnt;

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      phase_cnt <= '0;
    end else begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  assign ph1_en = (phase_cnt == `PH1_COUNT);
  assign ph2_en = (phase_cnt == `PH2_COUNT);

  // only moves at ph2, the next enable the core sees is ph1
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      core_rst <= 1'b1;
    end else if (ph2_en) begin
      core_rst <= ~core_run;
    end
  end

  a_phase_excl : assert property (@(posedge clk_8mhz) disable iff (rst) !(ph1_en && ph2_en));

endmodule

/* c64_bus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types of the system bus and the emulated machine side
// modules use scoped names on ports and a wildcard import in the body
////////////////////////////////////////////////////////////////////////////

`include "c64_bus_config.svh"

package c64_bus_pkg;

  // soft cpu bus side
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0] byte_strb_t;
  typedef logic [7:0] byte_t;

  // emulated machine side
  typedef logic [`MAIN_RAM_AW-1:0] main_addr_t;

  // bit 0 enables the overlay, bit 1 selects the short window
  typedef logic [1:0] osd_ctrl_t;

  typedef logic [63:0] kbd_mask_t;

  // bit 0 releases the core reset
  typedef logic [`MACHINE_CTRL_W-1:0] machine_ctrl_t;

  // ready state machine of the bus
  typedef enum logic [1:0] {
    IDLE,
    WAIT_LOAD,
    ACK
  } bus_state_e;

endpackage

/* c64_bus_config.svh */
////////////////////////////////////////////////////////////////////////////
// widths, address regions and register offsets of the system bus
// include wherever a module needs a width or a decode constant
////////////////////////////////////////////////////////////////////////////

`ifndef C64_BUS_CONFIG_SVH
`define C64_BUS_CONFIG_SVH

// 1 MHz phase enables out of the 8 MHz clock
`define PHASE_W 3
`define PH1_COUNT 3'd0
`define PH2_COUNT 3'd4

// memory sizes
`define SCRATCH_AW 10
`define MAIN_RAM_AW 16

// top nibble region codes and the load window
`define REGION_SCRATCH 4'h1
`define REGION_REGS 4'h3
`define LOAD_BASE 16'h5000

// register offsets inside region 3
`define REG_OSD 8'h00
`define REG_KBD_LO 8'h04
`define REG_KBD_HI 8'h08
`define REG_MACHINE 8'h0C

`define MACHINE_CTRL_W 7

`endif
